/* verilog/lc3Pkg.sv */
package lc3Pkg;

    // opcode field IR[15:12], LC-3 encoding with 1101 reused for LED
    typedef enum logic [3:0] {
        opBr   = 4'b0000,
        opAdd  = 4'b0001,
        opLd   = 4'b0010,
        opSt   = 4'b0011,
        opJsr  = 4'b0100,
        opAnd  = 4'b0101,
        opLdr  = 4'b0110,
        opStr  = 4'b0111,
        opRti  = 4'b1000,
        opNot  = 4'b1001,
        opLdi  = 4'b1010,
        opSti  = 4'b1011,
        opJmp  = 4'b1100,
        opLed  = 4'b1101,
        opLea  = 4'b1110,
        opTrap = 4'b1111
    } opcodeT;

    typedef enum logic [3:0] {
        fetchAddr,
        fetchMem,
        fetchIr,
        decode,
        execAlu,
        execLea,
        execBr,
        execJmp,
        execJsr,
        execLed,
        memAddr,
        memRead,
        memLoad,
        memStData,
        memWrite
    } stateT;

    // one driver on the shared bus at a time
    typedef enum logic [1:0] {busPc, busMdr, busAlu, busMarMux} busSelT;

    typedef enum logic [1:0] {aluAdd, aluAnd, aluNot, aluPassA} aluFnT;

    typedef enum logic [1:0] {pcInc, pcBus, pcAdder} pcSelT;

    typedef enum logic [1:0] {addr2Zero, addr2Off6, addr2Off9, addr2Off11} addr2SelT;

endpackage

/* verilog/lc3Ifs.sv */
// control signals into the datapath, IR and BEN back out
interface lc3CtrlIf import lc3Pkg::*; ();
    logic        ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
    busSelT      busSel;
    pcSelT       pcSel;
    aluFnT       aluFn;
    addr2SelT    addr2Sel;
    logic        drSel7;
    logic        sr1FromBaseR;
    logic        addr1FromReg;
    logic        mdrFromMem;
    logic [15:0] ir;
    logic        ben;

    modport ctrl (
        output ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
        output busSel, pcSel, aluFn, addr2Sel,
        output drSel7, sr1FromBaseR, addr1FromReg, mdrFromMem,
        input  ir, ben
    );

    modport dp (
        input  ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
        input  busSel, pcSel, aluFn, addr2Sel,
        input  drSel7, sr1FromBaseR, addr1FromReg, mdrFromMem,
        output ir, ben
    );
endinterface

// req is held until the one-cycle done pulse
interface lc3MemIf ();
    logic        req;
    logic        we;
    logic [15:0] addr;
    logic [15:0] wrData;
    logic [15:0] rdData;
    logic        done;

    modport ctrl (output req, we, input done);
    modport dp (output addr, wrData, input rdData);
    modport bus (input req, we, addr, wrData, output rdData, done);
endinterface

/* verilog/lc3RegFile.sv */
module lc3RegFile (
    input  logic        Clk,
    input  logic        reset,
    input  logic        we,
    input  logic [2:0]  dr,
    input  logic [2:0]  sr1,
    input  logic [2:0]  sr2,
    input  logic [15:0] wrData,
    output logic [15:0] sr1Out,
    output logic [15:0] sr2Out
);

    logic [15:0] regs [8];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[dr] <= wrData;
        end
    end

    // read ports see the old value during a write
    assign sr1Out = regs[sr1];
    assign sr2Out = regs[sr2];

endmodule

/* verilog/lc3Datapath.sv */
module lc3Datapath import lc3Pkg::*; #(
    parameter logic [15:0] resetPc = 16'h3000
) (
    input  logic        Clk,
    input  logic        reset,
    lc3CtrlIf.dp        ctrl,
    lc3MemIf.dp         mem,
    output logic [11:0] led
);

    logic [15:0] mar, mdr, ir, pc;
    logic [2:0]  nzp;
    logic        ben;

    logic [15:0] dataBus;
    logic [15:0] aluOut, aluB;
    logic [15:0] addr1, addr2, adderSum;
    logic [15:0] pcNext;
    logic [15:0] sr1Out, sr2Out;
    logic [2:0]  dr, sr1;
    logic [2:0]  nzpNext;

    // register file, written from the bus
    assign dr  = ctrl.drSel7 ? 3'd7 : ir[11:9];
    assign sr1 = ctrl.sr1FromBaseR ? ir[8:6] : ir[11:9];

    lc3RegFile uRegFile (
        .Clk    (Clk),
        .reset  (reset),
        .we     (ctrl.ldReg),
        .dr     (dr),
        .sr1    (sr1),
        .sr2    (ir[2:0]),
        .wrData (dataBus),
        .sr1Out (sr1Out),
        .sr2Out (sr2Out)
    );

    // IR[5] picks imm5 over SR2
    assign aluB = ir[5] ? {{11{ir[4]}}, ir[4:0]} : sr2Out;

    always_comb begin
        case (ctrl.aluFn)
            aluAdd:  aluOut = sr1Out + aluB;
            aluAnd:  aluOut = sr1Out & aluB;
            aluNot:  aluOut = ~sr1Out;
            default: aluOut = sr1Out;
        endcase
    end

    // address adder
    assign addr1 = ctrl.addr1FromReg ? sr1Out : pc;

    always_comb begin
        case (ctrl.addr2Sel)
            addr2Off6:  addr2 = {{10{ir[5]}}, ir[5:0]};
            addr2Off9:  addr2 = {{7{ir[8]}}, ir[8:0]};
            addr2Off11: addr2 = {{5{ir[10]}}, ir[10:0]};
            default:    addr2 = '0;
        endcase
    end

    assign adderSum = addr1 + addr2;

    always_comb begin
        case (ctrl.busSel)
            busPc:   dataBus = pc;
            busMdr:  dataBus = mdr;
            busAlu:  dataBus = aluOut;
            default: dataBus = adderSum;
        endcase
    end

    always_comb begin
        case (ctrl.pcSel)
            pcBus:   pcNext = dataBus;
            pcAdder: pcNext = adderSum;
            default: pcNext = pc + 16'd1;
        endcase
    end

    // condition codes from whatever is on the bus
    assign nzpNext = dataBus[15] ? 3'b100 : (dataBus == '0) ? 3'b010 : 3'b001;

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc  <= resetPc;
            ir  <= '0;
            nzp <= 3'b010;
            ben <= 1'b0;
            led <= '0;
        end else begin
            if (ctrl.ldPc) pc <= pcNext;
            if (ctrl.ldIr) ir <= dataBus;
            if (ctrl.ldCc) nzp <= nzpNext;
            if (ctrl.ldBen) ben <= |(ir[11:9] & nzp);
            if (ctrl.ldLed) led <= ir[11:0];
        end
    end

    always_ff @(posedge Clk) begin
        if (ctrl.ldMar) mar <= dataBus;
        if (ctrl.ldMdr) mdr <= ctrl.mdrFromMem ? mem.rdData : dataBus;
    end

    assign mem.addr   = mar;
    assign mem.wrData = mdr;
    assign ctrl.ir    = ir;
    assign ctrl.ben   = ben;

endmodule

/* verilog/lc3Control.sv */
module lc3Control import lc3Pkg::*; (
    input logic  Clk,
    input logic  reset,
    lc3CtrlIf.ctrl ctrl,
    lc3MemIf.ctrl  mem
);

    stateT  state, stateNext;
    opcodeT opcode;
    logic   baseRel;

    assign opcode  = opcodeT'(ctrl.ir[15:12]);
    // LDR and STR address off a base register
    assign baseRel = (opcode == opLdr) || (opcode == opStr);

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= fetchAddr;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext         = state;
        ctrl.ldMar        = 1'b0;
        ctrl.ldMdr        = 1'b0;
        ctrl.ldIr         = 1'b0;
        ctrl.ldBen        = 1'b0;
        ctrl.ldCc         = 1'b0;
        ctrl.ldReg        = 1'b0;
        ctrl.ldPc         = 1'b0;
        ctrl.ldLed        = 1'b0;
        ctrl.busSel       = busPc;
        ctrl.pcSel        = pcInc;
        ctrl.aluFn        = aluPassA;
        ctrl.addr2Sel     = addr2Zero;
        ctrl.drSel7       = 1'b0;
        ctrl.sr1FromBaseR = 1'b1;
        ctrl.addr1FromReg = 1'b0;
        ctrl.mdrFromMem   = 1'b0;
        mem.req           = 1'b0;
        mem.we            = 1'b0;

        case (state)
            fetchAddr: begin
                ctrl.busSel = busPc;
                ctrl.ldMar  = 1'b1;
                ctrl.ldPc   = 1'b1;
                stateNext   = fetchMem;
            end
            fetchMem: begin
                mem.req         = 1'b1;
                ctrl.mdrFromMem = 1'b1;
                ctrl.ldMdr      = mem.done;
                if (mem.done) stateNext = fetchIr;
            end
            fetchIr: begin
                ctrl.busSel = busMdr;
                ctrl.ldIr   = 1'b1;
                stateNext   = decode;
            end
            decode: begin
                ctrl.ldBen = 1'b1;
                case (opcode)
                    opAdd, opAnd, opNot:      stateNext = execAlu;
                    opBr:                     stateNext = execBr;
                    opJmp:                    stateNext = execJmp;
                    opJsr:                    stateNext = execJsr;
                    opLea:                    stateNext = execLea;
                    opLed:                    stateNext = execLed;
                    opLd, opLdr, opSt, opStr: stateNext = memAddr;
                    default:                  stateNext = fetchAddr;
                endcase
            end
            execAlu: begin
                ctrl.busSel = busAlu;
                ctrl.aluFn  = (opcode == opAnd) ? aluAnd :
                              (opcode == opNot) ? aluNot : aluAdd;
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
                stateNext   = fetchAddr;
            end
            execLea: begin
                ctrl.addr2Sel = addr2Off9;
                ctrl.busSel   = busMarMux;
                ctrl.ldReg    = 1'b1;
                stateNext     = fetchAddr;
            end
            execBr: begin
                ctrl.addr2Sel = addr2Off9;
                ctrl.pcSel    = pcAdder;
                ctrl.ldPc     = ctrl.ben;
                stateNext     = fetchAddr;
            end
            execJmp: begin
                // BaseR passes through the ALU onto the bus
                ctrl.busSel = busAlu;
                ctrl.pcSel  = pcBus;
                ctrl.ldPc   = 1'b1;
                stateNext   = fetchAddr;
            end
            execJsr: begin
                // link and jump share the edge, target uses the old R7
                ctrl.busSel       = busPc;
                ctrl.drSel7       = 1'b1;
                ctrl.ldReg        = 1'b1;
                ctrl.pcSel        = pcAdder;
                ctrl.ldPc         = 1'b1;
                ctrl.addr1FromReg = !ctrl.ir[11];
                ctrl.addr2Sel     = ctrl.ir[11] ? addr2Off11 : addr2Zero;
                stateNext         = fetchAddr;
            end
            execLed: begin
                ctrl.ldLed = 1'b1;
                stateNext  = fetchAddr;
            end
            memAddr: begin
                ctrl.addr1FromReg = baseRel;
                ctrl.addr2Sel     = baseRel ? addr2Off6 : addr2Off9;
                ctrl.busSel       = busMarMux;
                ctrl.ldMar        = 1'b1;
                stateNext = (opcode == opLd || opcode == opLdr) ? memRead : memStData;
            end
            memRead: begin
                mem.req         = 1'b1;
                ctrl.mdrFromMem = 1'b1;
                ctrl.ldMdr      = mem.done;
                if (mem.done) stateNext = memLoad;
            end
            memLoad: begin
                ctrl.busSel = busMdr;
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
                stateNext   = fetchAddr;
            end
            memStData: begin
                // store source is IR[11:9]
                ctrl.sr1FromBaseR = 1'b0;
                ctrl.busSel       = busAlu;
                ctrl.ldMdr        = 1'b1;
                stateNext         = memWrite;
            end
            memWrite: begin
                mem.req = 1'b1;
                mem.we  = 1'b1;
                if (mem.done) stateNext = fetchAddr;
            end
            default: stateNext = fetchAddr;
        endcase
    end

endmodule

/* verilog/lc3BusMaster.sv */
module lc3BusMaster (
    input  logic        Clk,
    input  logic        reset,
    lc3MemIf.bus        mem,
    output logic [15:0] wbAdr,
    output logic [15:0] wbDatO,
    input  logic [15:0] wbDatI,
    output logic        wbWe,
    output logic        wbCyc,
    output logic        wbStb,
    input  logic        wbAck
);

    typedef enum logic {bmIdle, bmActive} bmStateT;

    bmStateT state;
    logic    start, finish;

    // req is still high in the done cycle, so that cycle must not restart
    assign start  = (state == bmIdle) && mem.req && !mem.done;
    assign finish = (state == bmActive) && wbAck;

    always_ff @(posedge Clk) begin
        if (reset) begin
            state    <= bmIdle;
            wbCyc    <= 1'b0;
            wbStb    <= 1'b0;
            wbWe     <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= finish;
            if (start) begin
                state <= bmActive;
                wbCyc <= 1'b1;
                wbStb <= 1'b1;
                wbWe  <= mem.we;
            end else if (finish) begin
                state <= bmIdle;
                wbCyc <= 1'b0;
                wbStb <= 1'b0;
                wbWe  <= 1'b0;
            end
        end
    end

    // address and data held stable for the whole cycle
    always_ff @(posedge Clk) begin
        if (start) begin
            wbAdr  <= mem.addr;
            wbDatO <= mem.wrData;
        end
        if (finish) mem.rdData <= wbDatI;
    end

endmodule

/* verilog/lc3Top.sv */
module lc3Top #(
    parameter logic [15:0] resetPc = 16'h3000
) (
    input  logic        Clk,
    input  logic        reset,
    output logic [15:0] wbAdr,
    output logic [15:0] wbDatO,
    input  logic [15:0] wbDatI,
    output logic        wbWe,
    output logic        wbCyc,
    output logic        wbStb,
    input  logic        wbAck,
    output logic [11:0] led
);

    lc3CtrlIf ctrlBus ();
    lc3MemIf  memBus ();

    lc3Control uControl (
        .Clk   (Clk),
        .reset (reset),
        .ctrl  (ctrlBus.ctrl),
        .mem   (memBus.ctrl)
    );

    lc3Datapath #(.resetPc(resetPc)) uDatapath (
        .Clk   (Clk),
        .reset (reset),
        .ctrl  (ctrlBus.dp),
        .mem   (memBus.dp),
        .led   (led)
    );

    lc3BusMaster uBusMaster (
        .Clk    (Clk),
        .reset  (reset),
        .mem    (memBus.bus),
        .wbAdr  (wbAdr),
        .wbDatO (wbDatO),
        .wbDatI (wbDatI),
        .wbWe   (wbWe),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbAck  (wbAck)
    );

endmodule

/* sim/lc3Tb.sv */
module lc3Tb import lc3Pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] startPc = 16'h3000;
    localparam int runLimit = 20000;
    localparam int eventLimit = 2000;

    logic        Clk;
    logic        reset;
    logic [15:0] wbAdr, wbDatO, wbDatI;
    logic        wbWe, wbCyc, wbStb, wbAck;
    logic [11:0] led;

    logic [15:0] mem [65536];
    logic [15:0] refMem [65536];
    logic [15:0] cur;
    logic [15:0] lfsr = 16'd17507;

    logic [15:0] expWrAddr [$];
    logic [15:0] expWrData [$];
    logic [15:0] obsWrAddr [$];
    logic [15:0] obsWrData [$];
    logic [11:0] expLed [$];
    logic [11:0] obsLed [$];
    logic [15:0] expRdAddr [$];
    int          expRdTest [$];
    logic [15:0] obsRdAddr [$];

    int    errs [1:6];
    int    checks [1:6];
    int    stray = 0;
    string names [1:6];
    logic  refReady = 1'b0;
    logic  compareDone = 1'b0;
    logic  loopSeen = 1'b0;

    lc3Top #(.resetPc(startPc)) u_dut (
        .Clk    (Clk),
        .reset  (reset),
        .wbAdr  (wbAdr),
        .wbDatO (wbDatO),
        .wbDatI (wbDatI),
        .wbWe   (wbWe),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbAck  (wbAck),
        .led    (led)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] sext(logic [15:0] v, int bits);
        logic [15:0] s;
        s = v << (16 - bits);
        return $signed(s) >>> (16 - bits);
    endfunction

    function automatic logic [2:0] ccOf(logic [15:0] v);
        if (v[15]) return 3'b100;
        if (v == 16'h0000) return 3'b010;
        return 3'b001;
    endfunction

    // instruction encoders with offsets from the current load address
    function automatic logic [15:0] aluImm(logic [3:0] op, int dr, int sr, int imm);
        return {op, 3'(dr), 3'(sr), 1'b1, 5'(imm)};
    endfunction

    function automatic logic [15:0] aluReg(logic [3:0] op, int dr, int sr1, int sr2);
        return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
    endfunction

    function automatic logic [15:0] notOp(int dr, int sr);
        return {opNot, 3'(dr), 3'(sr), 6'h3F};
    endfunction

    function automatic logic [15:0] pcRel(logic [3:0] op, int r, logic [15:0] target);
        logic [15:0] off;
        off = target - (cur + 16'd1);
        return {op, 3'(r), off[8:0]};
    endfunction

    function automatic logic [15:0] baseRel(logic [3:0] op, int r, int base, int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    function automatic logic [15:0] jsrTo(logic [15:0] target);
        logic [15:0] off;
        off = target - (cur + 16'd1);
        return {opJsr, 1'b1, off[10:0]};
    endfunction

    task automatic emit(logic [15:0] w);
        mem[cur] = w;
        cur = cur + 16'd1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = {i[7:0], i[15:8]} ^ 16'h5A3C;
        end
        mem[16'h30C0] = 16'h8001;
        mem[16'h30C2] = 16'h7F00;
        mem[16'h30C7] = 16'hBEEF;
        mem[16'h2FF8] = 16'h0123;
        cur = startPc;
        // arithmetic and logic results go to 3080..
        emit(aluImm(opAdd, 1, 0, 7));
        emit(aluImm(opAdd, 2, 1, -3));
        emit(aluReg(opAdd, 3, 1, 2));
        emit(notOp(4, 3));
        emit(aluReg(opAnd, 5, 4, 1));
        emit(aluImm(opAnd, 6, 4, -16));
        emit(aluReg(opAdd, 7, 4, 2));
        emit(pcRel(opSt, 3, 16'h3080));
        emit(pcRel(opSt, 4, 16'h3081));
        emit(pcRel(opSt, 5, 16'h3082));
        emit(pcRel(opSt, 6, 16'h3083));
        emit(pcRel(opSt, 7, 16'h3084));
        emit({opLed, 12'h0A5});
        // loads and stores both sides of the code
        emit(pcRel(opLd, 1, 16'h30C0));
        emit(pcRel(opLd, 2, 16'h2FF8));
        emit(pcRel(opLea, 3, 16'h30C4));
        emit(baseRel(opLdr, 4, 3, -2));
        emit(baseRel(opLdr, 5, 3, 3));
        emit(pcRel(opLea, 6, 16'h2FF0));
        emit(baseRel(opStr, 1, 6, 5));
        emit(baseRel(opStr, 2, 6, -4));
        emit(baseRel(opStr, 4, 3, 31));
        emit(pcRel(opSt, 5, 16'h2FFA));
        emit(pcRel(opSt, 3, 16'h3090));
        emit(pcRel(opSt, 6, 16'h3091));
        emit({opLed, 12'h5C3});
        // a store to 30AF means a wrong branch decision
        emit(aluImm(opAdd, 1, 0, -1));
        emit(pcRel(opBr, 4, cur + 16'd2));
        emit(pcRel(opSt, 1, 16'h30AF));
        emit(pcRel(opBr, 3, cur + 16'd2));
        emit(pcRel(opSt, 1, 16'h30A0));
        emit(aluImm(opAnd, 2, 0, 0));
        emit(pcRel(opBr, 2, cur + 16'd2));
        emit(pcRel(opSt, 1, 16'h30AF));
        emit(pcRel(opBr, 5, cur + 16'd2));
        emit(pcRel(opSt, 1, 16'h30A1));
        emit(aluImm(opAdd, 3, 0, 5));
        emit(pcRel(opBr, 1, cur + 16'd2));
        emit(pcRel(opSt, 1, 16'h30AF));
        emit(pcRel(opBr, 6, cur + 16'd2));
        emit(pcRel(opSt, 3, 16'h30A2));
        emit(pcRel(opLea, 4, cur + 16'd3));
        emit({opJmp, 3'b000, 3'd4, 6'd0});
        emit(pcRel(opSt, 1, 16'h30AF));
        emit(jsrTo(16'h3060));
        emit(pcRel(opLea, 5, 16'h3068));
        emit({opJsr, 3'b000, 3'd5, 6'd0});
        emit({opLed, 12'h801});
        emit(pcRel(opBr, 7, cur));
        // subroutines store their link, then return through R7
        cur = 16'h3060;
        emit(pcRel(opSt, 7, 16'h30A4));
        emit({opJmp, 3'b000, 3'd7, 6'd0});
        cur = 16'h3068;
        emit(pcRel(opSt, 7, 16'h30A5));
        emit({opJmp, 3'b000, 3'd7, 6'd0});
    endtask

    // instruction-set model that stops on a taken branch to itself
    function automatic void runReference();
        logic [15:0] r [8];
        logic [15:0] pc;
        logic [15:0] ir;
        logic [15:0] ea;
        logic [15:0] val;
        logic [2:0]  nzp;
        logic [11:0] ledNow;
        logic        halted;
        int          steps;
        opcodeT      op;
        for (int i = 0; i < 8; i++) begin
            r[i] = 16'h0000;
        end
        pc = startPc;
        nzp = 3'b010;
        ledNow = 12'h000;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 1000) begin
            ir = refMem[pc];
            expRdAddr.push_back(pc);
            expRdTest.push_back(4);
            pc = pc + 16'd1;
            steps++;
            op = opcodeT'(ir[15:12]);
            case (op)
                opAdd, opAnd: begin
                    val = ir[5] ? sext(ir, 5) : r[ir[2:0]];
                    val = (op == opAdd) ? r[ir[8:6]] + val : r[ir[8:6]] & val;
                    r[ir[11:9]] = val;
                    nzp = ccOf(val);
                end
                opNot: begin
                    val = ~r[ir[8:6]];
                    r[ir[11:9]] = val;
                    nzp = ccOf(val);
                end
                opBr: begin
                    if ((ir[11:9] & nzp) != 3'b000) begin
                        ea = pc + sext(ir, 9);
                        halted = (ea == pc - 16'd1);
                        pc = ea;
                    end
                end
                opJmp: pc = r[ir[8:6]];
                opJsr: begin
                    val = pc;
                    pc = ir[11] ? pc + sext(ir, 11) : r[ir[8:6]];
                    r[7] = val;
                end
                opLd, opLdr: begin
                    ea = (op == opLd) ? pc + sext(ir, 9) : r[ir[8:6]] + sext(ir, 6);
                    val = refMem[ea];
                    expRdAddr.push_back(ea);
                    expRdTest.push_back(3);
                    r[ir[11:9]] = val;
                    nzp = ccOf(val);
                end
                opLea: r[ir[11:9]] = pc + sext(ir, 9);
                opSt, opStr: begin
                    ea = (op == opSt) ? pc + sext(ir, 9) : r[ir[8:6]] + sext(ir, 6);
                    refMem[ea] = r[ir[11:9]];
                    expWrAddr.push_back(ea);
                    expWrData.push_back(r[ir[11:9]]);
                end
                opLed: begin
                    if (ir[11:0] != ledNow) begin
                        ledNow = ir[11:0];
                        expLed.push_back(ledNow);
                    end
                end
                default: ;
            endcase
        end
    endfunction

    // write regions tell the tests apart
    function automatic int writeTest(logic [15:0] a);
        if (a >= 16'h3080 && a < 16'h3090) return 2;
        if (a >= 16'h30A0 && a < 16'h30B0) return 4;
        return 3;
    endfunction

    // wishbone slave with 0 to 3 wait cycles per access
    initial begin : slaveModel
        logic        busy;
        logic        first;
        logic        prevValid;
        logic [15:0] prevRd;
        logic [15:0] adrHeld;
        logic [15:0] datHeld;
        logic        weHeld;
        int          waitCnt;
        busy = 1'b0;
        first = 1'b1;
        prevValid = 1'b0;
        prevRd = 16'h0000;
        waitCnt = 0;
        forever begin
            @(posedge Clk);
            #1;
            if (wbAck) begin
                wbAck = 1'b0;
            end else if (busy || (wbCyc && wbStb)) begin
                if (!busy) begin
                    busy = 1'b1;
                    adrHeld = wbAdr;
                    datHeld = wbDatO;
                    weHeld = wbWe;
                    waitCnt = lfsrStep() ? 2 : 0;
                    if (lfsrStep()) waitCnt++;
                    if (first) begin
                        checks[1]++;
                        assert (!wbWe && wbAdr == startPc) else begin
                            $display("Mismatch %s: expected read %h actual we=%b adr %h",
                                     names[1], startPc, wbWe, wbAdr);
                            errs[1]++;
                        end
                        first = 1'b0;
                    end
                    if (!wbWe) begin
                        if (prevValid && wbAdr == prevRd) loopSeen = 1'b1;
                        prevValid = 1'b1;
                        prevRd = wbAdr;
                    end else begin
                        prevValid = 1'b0;
                    end
                end
                checks[6]++;
                assert (wbCyc && wbStb && wbAdr == adrHeld && wbWe == weHeld
                        && (!weHeld || wbDatO == datHeld)) else begin
                    $display("%s: strobe or address changed before ack at %h",
                             names[6], adrHeld);
                    errs[6]++;
                end
                if (waitCnt == 0) begin
                    busy = 1'b0;
                    wbAck = 1'b1;
                    if (wbWe) begin
                        mem[wbAdr] = wbDatO;
                        obsWrAddr.push_back(wbAdr);
                        obsWrData.push_back(wbDatO);
                    end else begin
                        wbDatI = mem[wbAdr];
                        obsRdAddr.push_back(wbAdr);
                    end
                end else begin
                    waitCnt--;
                end
            end
        end
    end

    initial begin : ledWatch
        logic [11:0] prev;
        prev = 12'h000;
        forever begin
            @(negedge Clk);
            if (!reset && led != prev) begin
                obsLed.push_back(led);
                prev = led;
            end
        end
    end

    initial begin : compareProc
        int   t;
        int   wt;
        logic stop;
        wt = 0;
        while (!refReady && wt < eventLimit) begin
            @(posedge Clk);
            wt++;
        end
        stop = !refReady;
        for (int n = 0; n < expWrAddr.size() && !stop; n++) begin
            t = writeTest(expWrAddr[n]);
            wt = 0;
            while (obsWrAddr.size() == 0 && wt < eventLimit) begin
                @(negedge Clk);
                wt++;
            end
            if (obsWrAddr.size() == 0) begin
                $display("%s: expected write %0d to %h never happened",
                         names[t], n, expWrAddr[n]);
                errs[t]++;
                stop = 1'b1;
            end else begin
                checks[t]++;
                assert (obsWrAddr[0] == expWrAddr[n] && obsWrData[0] == expWrData[n]) else begin
                    $display("Mismatch %s: write %0d expected %h=%h actual %h=%h", names[t], n,
                             expWrAddr[n], expWrData[n], obsWrAddr[0], obsWrData[0]);
                    errs[t]++;
                end
                void'(obsWrAddr.pop_front());
                void'(obsWrData.pop_front());
            end
        end
        for (int n = 0; n < expLed.size() && !stop; n++) begin
            wt = 0;
            while (obsLed.size() == 0 && wt < eventLimit) begin
                @(negedge Clk);
                wt++;
            end
            if (obsLed.size() == 0) begin
                $display("%s: LED value %0d never appeared", names[5], n);
                errs[5]++;
                stop = 1'b1;
            end else begin
                checks[5]++;
                assert (obsLed[0] == expLed[n]) else begin
                    $display("Mismatch %s: LED %0d expected %h actual %h",
                             names[5], n, expLed[n], obsLed[0]);
                    errs[5]++;
                end
                void'(obsLed.pop_front());
            end
        end
        // fetches and load reads in program order
        for (int n = 0; n < expRdAddr.size() && !stop; n++) begin
            t = expRdTest[n];
            wt = 0;
            while (obsRdAddr.size() == 0 && wt < eventLimit) begin
                @(negedge Clk);
                wt++;
            end
            if (obsRdAddr.size() == 0) begin
                $display("%s: expected read %0d from %h never happened",
                         names[t], n, expRdAddr[n]);
                errs[t]++;
                stop = 1'b1;
            end else begin
                checks[t]++;
                assert (obsRdAddr[0] == expRdAddr[n]) else begin
                    $display("Mismatch %s: read %0d expected %h actual %h",
                             names[t], n, expRdAddr[n], obsRdAddr[0]);
                    errs[t]++;
                end
                void'(obsRdAddr.pop_front());
            end
        end
        compareDone = 1'b1;
    end

    initial begin
        int cyc;
        int bad;
        int totalChecks;
        int totalErrs;
        reset = 1'b1;
        wbDatI = 16'h0000;
        wbAck = 1'b0;
        names[1] = "reset and fetch";
        names[2] = "arithmetic and logic";
        names[3] = "memory addressing";
        names[4] = "control flow";
        names[5] = "led";
        names[6] = "back-pressure";
        for (int k = 1; k <= 6; k++) begin
            errs[k] = 0;
            checks[k] = 0;
        end
        loadProgram();
        for (int i = 0; i < 65536; i++) begin
            refMem[i] = mem[i];
        end
        runReference();
        refReady = 1'b1;
        repeat (5) @(posedge Clk);
        #1;
        reset = 1'b0;
        checks[1]++;
        assert (led == 12'h000) else begin
            $display("Mismatch %s: led after reset expected %h actual %h",
                     names[1], 12'h000, led);
            errs[1]++;
        end
        cyc = 0;
        while (!(loopSeen && compareDone) && cyc < runLimit) begin
            @(posedge Clk);
            cyc++;
        end
        if (!(loopSeen && compareDone)) begin
            $display("timeout: program did not reach its final loop within %0d cycles",
                     runLimit);
            stray++;
        end
        checks[4]++;
        assert (obsWrAddr.size() == 0 && obsLed.size() == 0) else begin
            $display("%s: writes or LED changes seen beyond the expected ones", names[4]);
            errs[4]++;
        end
        totalChecks = 0;
        totalErrs = stray;
        for (int k = 1; k <= 6; k++) begin
            // back-pressure only holds if every result under random waits held
            bad = errs[k] + ((k == 6) ? errs[2] + errs[3] + errs[4] + errs[5] : 0);
            $display("test %0d %s: %s (%0d checks, %0d errors)", k, names[k],
                     (bad == 0) ? "ok" : "FAILED", checks[k], errs[k]);
            totalChecks += checks[k];
            totalErrs += errs[k];
        end
        $display("total: %0d checks, %0d errors", totalChecks, totalErrs);
        if (totalErrs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* lc3Top.f */
verilog/lc3Pkg.sv
verilog/lc3Ifs.sv
verilog/lc3RegFile.sv
verilog/lc3Datapath.sv
verilog/lc3Control.sv
verilog/lc3BusMaster.sv
verilog/lc3Top.sv
sim/lc3Tb.sv

/* Makefile */
# Verilator build and run of the LC-3 core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module lc3Tb -Mdir obj_dir -f lc3Top.f
	./obj_dir/Vlc3Tb | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
